//--- verilog/fmv_regs_pkg.sv
`default_nettype none

package fmv_regs_pkg;

    // Host bus, word addressed
    localparam int addr_width = 15;
    localparam int data_width = 16;

    // Register word addresses
    localparam logic [addr_width-1:0] reg_timecd_hi = 15'h202c;
    localparam logic [addr_width-1:0] reg_timecd_lo = 15'h202d;
    localparam logic [addr_width-1:0] reg_tmpref    = 15'h202e; // Reference at bits 11..2
    localparam logic [addr_width-1:0] reg_ier       = 15'h2030;
    localparam logic [addr_width-1:0] reg_isr       = 15'h2031; // Clear on read
    localparam logic [addr_width-1:0] reg_tcnt      = 15'h2032;
    localparam logic [addr_width-1:0] reg_trld      = 15'h2057; // Write restarts timer
    localparam logic [addr_width-1:0] reg_xfer      = 15'h206f; // Stream data, high byte first

    // Status and enable bit positions
    localparam int isr_seq   = 0;
    localparam int isr_gop   = 1;
    localparam int isr_pic   = 2;
    localparam int isr_tim   = 8;
    localparam int isr_vsync = 11;

    // System tick from the core clock
    localparam int tick_width = 10;
    localparam logic [tick_width-1:0] tick_divider = 10'd667;

    // Counter advances once per 8 ticks
    localparam int timer_prescale_bits = 3;
    localparam logic [data_width-1:0] tcnt_reset = 16'd55;

endpackage

`default_nettype wire

//--- verilog/fmv_stream_pkg.sv
`default_nettype none

package fmv_stream_pkg;

    // Start code prefix 00 00 01 and the code byte after it
    localparam logic [7:0] prefix_zero = 8'h00;
    localparam logic [7:0] prefix_one  = 8'h01;
    localparam logic [7:0] code_seq    = 8'hb3;
    localparam logic [7:0] code_gop    = 8'hb8;
    localparam logic [7:0] code_pic    = 8'h00;
    localparam logic [7:0] code_slice  = 8'h01;

    typedef enum logic [3:0] {
        idle,
        magic0,
        magic2,
        magic_match,
        seqhdr,
        gop0,
        gop1,
        gop2,
        gop3,
        pic0,
        pic1,
        pic2,
        pic3,
        slice0
    } parser_state_e;

    localparam int tmpref_width   = 10;
    localparam int timecode_width = 32;

    // Header event queue
    localparam int fifo_depth      = 64;
    localparam int fifo_addr_width = 6;

endpackage

`default_nettype wire

//--- verilog/fmv_host_regs.sv
`timescale 1ns/1ps
`default_nettype none

module fmv_host_regs (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire  [fmv_regs_pkg::addr_width-1:0]        address,
    input  wire  [fmv_regs_pkg::data_width-1:0]        din,
    output logic [fmv_regs_pkg::data_width-1:0]        dout,
    input  wire                                        cs,
    input  wire                                        uds,
    input  wire                                        lds,
    input  wire                                        write_strobe,
    output logic                                       bus_ack,
    output logic                                       intreq,
    input  wire                                        vsync,
    output logic [7:0]                                 stream_byte,
    output logic                                       stream_valid,
    input  wire                                        ev_valid,
    input  wire                                        ev_seq,
    input  wire                                        ev_gop,
    input  wire                                        ev_pic,
    input  wire  [fmv_stream_pkg::timecode_width-1:0]  ev_timecode,
    input  wire  [fmv_stream_pkg::tmpref_width-1:0]    ev_tmpref,
    output logic                                       ev_pop,
    input  wire                                        timer_hit,
    output logic [fmv_regs_pkg::data_width-1:0]        tcnt,
    output logic                                       timer_reload
);
    import fmv_regs_pkg::*;
    import fmv_stream_pkg::*;

    logic                      access;
    logic                      bus_write;
    logic                      bus_read;
    logic                      xfer_write;
    logic                      low_pending;  // Low byte goes out next cycle
    logic [7:0]                low_byte;
    logic                      vsync_q;
    logic                      vsync_rise;
    logic                      field_toggle;
    logic [data_width-1:0]     ier;
    logic [data_width-1:0]     isr;
    logic [data_width-1:0]     tmpref;
    logic [timecode_width-1:0] timecode;

    assign access     = cs && (uds || lds);
    assign bus_write  = access && bus_ack && write_strobe;
    assign bus_read   = access && bus_ack && !write_strobe;
    assign xfer_write = bus_write && (address == reg_xfer);

    // High byte straight from the bus, low byte one cycle later
    assign stream_valid = xfer_write || low_pending;
    assign stream_byte  = low_pending ? low_byte : din[data_width-1:8];

    assign vsync_rise   = vsync && !vsync_q;
    assign ev_pop       = ev_valid && vsync_rise && field_toggle; // Every second field
    assign timer_reload = bus_write && (address == reg_trld);
    assign intreq       = (isr & ier) != '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_ack      <= 1'b0;
            low_pending  <= 1'b0;
            vsync_q      <= 1'b0;
            field_toggle <= 1'b0;
            ier          <= '0;
            isr          <= '0;
            tcnt         <= tcnt_reset;
        end else begin
            bus_ack     <= access ? !bus_ack : 1'b0;
            low_pending <= xfer_write;
            vsync_q     <= vsync;
            if (vsync_rise)
                field_toggle <= !field_toggle;

            if (bus_write) begin
                case (address)
                    reg_ier:  ier <= din;
                    reg_tcnt: tcnt <= din;
                    default: ;
                endcase
            end

            // A set in the same cycle as the clearing read survives
            if (bus_read && address == reg_isr)
                isr <= '0;
            if (vsync_rise)
                isr[isr_vsync] <= 1'b1;
            if (timer_hit)
                isr[isr_tim] <= 1'b1;
            if (ev_pop) begin
                isr[isr_seq] <= ev_seq;
                isr[isr_gop] <= ev_gop;
                isr[isr_pic] <= ev_pic;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_write)
            low_byte <= din[7:0];
        if (ev_pop) begin
            timecode <= ev_timecode;
            tmpref   <= {{(data_width - tmpref_width - 2){1'b0}}, ev_tmpref, 2'b00};
        end
    end

    always_comb begin
        case (address)
            reg_timecd_hi: dout = timecode[31:16];
            reg_timecd_lo: dout = timecode[15:0];
            reg_tmpref:    dout = tmpref;
            reg_ier:       dout = ier;
            reg_isr:       dout = isr;
            reg_tcnt:      dout = tcnt;
            default:       dout = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/fmv_header_parser.sv
`timescale 1ns/1ps
`default_nettype none

module fmv_header_parser (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire  [7:0]                                 stream_byte,
    input  wire                                        stream_valid,
    output logic                                       event_write,
    output logic                                       ev_seq,
    output logic                                       ev_gop,
    output logic                                       ev_pic,
    output logic [fmv_stream_pkg::timecode_width-1:0]  ev_timecode,
    output logic [fmv_stream_pkg::tmpref_width-1:0]    ev_tmpref
);
    import fmv_stream_pkg::*;

    parser_state_e           state;
    logic [tmpref_width-1:0] pic_ref;       // Reference of the header being parsed
    logic [tmpref_width-1:0] expected_ref;  // Next in-order reference within the GOP

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= idle;
            event_write  <= 1'b0;
            ev_seq       <= 1'b0;
            ev_gop       <= 1'b0;
            ev_pic       <= 1'b0;
            ev_timecode  <= '0;
            ev_tmpref    <= '0;
            pic_ref      <= '0;
            expected_ref <= '0;
        end else begin
            event_write <= 1'b0;

            // Flags belong to one event only
            if (event_write) begin
                ev_seq <= 1'b0;
                ev_gop <= 1'b0;
                ev_pic <= 1'b0;
            end

            if (stream_valid) begin
                state <= idle;  // Unexpected byte drops the match
                case (state)
                    idle: begin
                        if (stream_byte == prefix_zero)
                            state <= magic0;
                    end
                    magic0: begin
                        if (stream_byte == prefix_zero)
                            state <= magic2;
                    end
                    magic2: begin
                        if (stream_byte == prefix_zero)
                            state <= magic2;  // Extra zero stuffing
                        else if (stream_byte == prefix_one)
                            state <= magic_match;
                    end
                    magic_match: begin
                        case (stream_byte)
                            code_seq:   state <= seqhdr;
                            code_gop:   state <= gop0;
                            code_pic:   state <= pic0;
                            code_slice: state <= slice0;
                            default: ;
                        endcase
                    end
                    seqhdr: ev_seq <= 1'b1;
                    gop0:   state <= gop1;
                    gop1: begin
                        ev_timecode[27:25] <= stream_byte[2:0];
                        state <= gop2;
                    end
                    gop2: begin
                        ev_timecode[24:22] <= stream_byte[7:5];
                        ev_timecode[21:17] <= stream_byte[4:0];
                        state <= gop3;
                    end
                    gop3: begin
                        ev_timecode[16] <= stream_byte[7];
                        ev_gop          <= 1'b1;
                        expected_ref    <= '0;  // New GOP counts from zero
                    end
                    pic0: begin
                        pic_ref[9:2] <= stream_byte;
                        state <= pic1;
                    end
                    pic1: begin
                        pic_ref[1:0] <= stream_byte[7:6];
                        state <= pic2;
                    end
                    pic2: begin
                        // Out of order pictures keep the last reference
                        if (pic_ref == expected_ref) begin
                            ev_tmpref    <= pic_ref;
                            expected_ref <= expected_ref + 1'b1;
                        end
                        state <= pic3;
                    end
                    pic3: begin
                        ev_pic      <= 1'b1;
                        event_write <= 1'b1;
                    end
                    default: ;  // slice0 returns to idle
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/fmv_system_timer.sv
`timescale 1ns/1ps
`default_nettype none

module fmv_system_timer (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire  [fmv_regs_pkg::data_width-1:0]  tcnt,
    input  wire                                  timer_reload,
    output logic                                 timer_hit
);
    import fmv_regs_pkg::*;

    localparam int cnt_width = data_width + timer_prescale_bits;

    logic [tick_width-1:0] div_cnt;
    logic                  tick;
    logic [cnt_width-1:0]  timer_cnt;
    logic                  at_compare;

    assign tick = div_cnt == tick_divider - 1'b1;

    // Last tick of the prescaled step equal to tcnt
    assign at_compare = (timer_cnt[cnt_width-1:timer_prescale_bits] == tcnt) &&
                        (&timer_cnt[timer_prescale_bits-1:0]);

    always_ff @(posedge clk) begin
        if (reset) begin
            div_cnt   <= '0;
            timer_cnt <= '0;
            timer_hit <= 1'b0;
        end else begin
            timer_hit <= 1'b0;
            if (timer_reload) begin
                div_cnt   <= '0;
                timer_cnt <= '0;
            end else if (tick) begin
                div_cnt <= '0;
                if (at_compare) begin
                    timer_hit <= 1'b1;
                    timer_cnt <= '0;
                end else begin
                    timer_cnt <= timer_cnt + 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/fmv_event_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module fmv_event_fifo (
    input  wire                                        clk,
    input  wire                                        reset,
    input  wire                                        event_write,
    input  wire                                        ev_seq,
    input  wire                                        ev_gop,
    input  wire                                        ev_pic,
    input  wire  [fmv_stream_pkg::timecode_width-1:0]  ev_timecode,
    input  wire  [fmv_stream_pkg::tmpref_width-1:0]    ev_tmpref,
    input  wire                                        ev_pop,
    output logic                                       ev_valid,
    output logic                                       ev_head_seq,
    output logic                                       ev_head_gop,
    output logic                                       ev_head_pic,
    output logic [fmv_stream_pkg::timecode_width-1:0]  ev_head_timecode,
    output logic [fmv_stream_pkg::tmpref_width-1:0]    ev_head_tmpref
);
    import fmv_stream_pkg::*;

    localparam int entry_width = 3 + timecode_width + tmpref_width;

    logic [entry_width-1:0]     mem [fifo_depth];
    logic [fifo_addr_width-1:0] wr_idx;
    logic [fifo_addr_width-1:0] rd_idx;
    logic [fifo_addr_width:0]   count;
    logic                       do_write;
    logic                       do_pop;

    // Full FIFO drops the event
    assign do_write = event_write && (count != (fifo_addr_width + 1)'(fifo_depth));
    assign do_pop   = ev_pop && ev_valid;
    assign ev_valid = count != '0;

    // Head shows without a read request
    assign {ev_head_seq, ev_head_gop, ev_head_pic, ev_head_timecode, ev_head_tmpref} =
        mem[rd_idx];

    always_ff @(posedge clk) begin
        if (do_write)
            mem[wr_idx] <= {ev_seq, ev_gop, ev_pic, ev_timecode, ev_tmpref};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (do_write)
                wr_idx <= wr_idx + 1'b1;
            if (do_pop)
                rd_idx <= rd_idx + 1'b1;
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/fmv_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module fmv_decoder (
    input  wire                                  clk,
    input  wire                                  reset,
    input  wire  [fmv_regs_pkg::addr_width-1:0]  address,
    input  wire  [fmv_regs_pkg::data_width-1:0]  din,
    output logic [fmv_regs_pkg::data_width-1:0]  dout,
    input  wire                                  cs,
    input  wire                                  uds,
    input  wire                                  lds,
    input  wire                                  write_strobe,
    output logic                                 bus_ack,
    output logic                                 intreq,
    input  wire                                  vsync
);
    import fmv_regs_pkg::*;
    import fmv_stream_pkg::*;

    logic [7:0]                stream_byte;
    logic                      stream_valid;
    logic                      event_write;
    logic                      push_seq;
    logic                      push_gop;
    logic                      push_pic;
    logic [timecode_width-1:0] push_timecode;
    logic [tmpref_width-1:0]   push_tmpref;
    logic                      ev_valid;
    logic                      ev_pop;
    logic                      head_seq;
    logic                      head_gop;
    logic                      head_pic;
    logic [timecode_width-1:0] head_timecode;
    logic [tmpref_width-1:0]   head_tmpref;
    logic [data_width-1:0]     tcnt;
    logic                      timer_reload;
    logic                      timer_hit;

    fmv_host_regs host_regs_i (
        .clk(clk), .reset(reset), .address(address), .din(din), .dout(dout),
        .cs(cs), .uds(uds), .lds(lds), .write_strobe(write_strobe),
        .bus_ack(bus_ack), .intreq(intreq), .vsync(vsync),
        .stream_byte(stream_byte), .stream_valid(stream_valid),
        .ev_valid(ev_valid), .ev_seq(head_seq), .ev_gop(head_gop), .ev_pic(head_pic),
        .ev_timecode(head_timecode), .ev_tmpref(head_tmpref), .ev_pop(ev_pop),
        .timer_hit(timer_hit), .tcnt(tcnt), .timer_reload(timer_reload)
    );

    fmv_header_parser parser_i (
        .clk(clk), .reset(reset), .stream_byte(stream_byte), .stream_valid(stream_valid),
        .event_write(event_write), .ev_seq(push_seq), .ev_gop(push_gop),
        .ev_pic(push_pic), .ev_timecode(push_timecode), .ev_tmpref(push_tmpref)
    );

    fmv_event_fifo event_fifo_i (
        .clk(clk), .reset(reset), .event_write(event_write),
        .ev_seq(push_seq), .ev_gop(push_gop), .ev_pic(push_pic),
        .ev_timecode(push_timecode), .ev_tmpref(push_tmpref),
        .ev_pop(ev_pop), .ev_valid(ev_valid),
        .ev_head_seq(head_seq), .ev_head_gop(head_gop), .ev_head_pic(head_pic),
        .ev_head_timecode(head_timecode), .ev_head_tmpref(head_tmpref)
    );

    fmv_system_timer timer_i (
        .clk(clk), .reset(reset), .tcnt(tcnt),
        .timer_reload(timer_reload), .timer_hit(timer_hit)
    );

endmodule

`default_nettype wire

//--- dv/fmv_decoder_props.sv
`timescale 1ns/1ps
`default_nettype none

module fmv_decoder_props (
    input wire                                 clk,
    input wire                                 reset,
    input wire                                 bus_ack,
    input wire                                 intreq,
    input wire                                 stream_valid,
    input wire [fmv_regs_pkg::data_width-1:0]  isr,
    input wire [fmv_regs_pkg::data_width-1:0]  ier
);

    // Level request follows enabled status
    intreq_follows_status: assert property (
        @(posedge clk) disable iff (reset)
        intreq == ((isr & ier) != '0)
    ) else $error("intreq differs from enabled status");

    // Acknowledge toggles while an access is held
    ack_single_cycle: assert property (
        @(posedge clk) disable iff (reset)
        bus_ack |=> !bus_ack
    ) else $error("bus_ack high for two cycles in a row");

    // High byte then low byte, never a third
    stream_two_bytes: assert property (
        @(posedge clk) disable iff (reset)
        (stream_valid && $past(stream_valid)) |=> !stream_valid
    ) else $error("stream_valid held longer than two cycles");

endmodule

bind fmv_host_regs fmv_decoder_props props_i (
    .clk(clk),
    .reset(reset),
    .bus_ack(bus_ack),
    .intreq(intreq),
    .stream_valid(stream_valid),
    .isr(isr),
    .ier(ier)
);

`default_nettype wire

//--- dv/fmv_decoder_tb.sv
`timescale 1ns/1ps
`default_nettype none

module fmv_decoder_tb;
    import fmv_regs_pkg::*;

    localparam int n_entries = 4;
    localparam int n_words = 32;
    localparam logic [15:0] filler_mark = 16'hffff;  // Replaced by a random word
    localparam int timer_cycles = (1 << timer_prescale_bits) * int'(tick_divider);
    localparam int watchdog_cycles = n_entries * 300 + timer_cycles + 2000;

    // Transfer words of all entries back to back
    localparam logic [15:0] stim_words [n_words] = '{
        16'h0000, 16'h01b3, 16'h1122, filler_mark, 16'h0000, 16'h01b8, 16'h1205,
        16'ha680, filler_mark, 16'h0000, 16'h0100, 16'h0000, 16'h5a5a,
        filler_mark, 16'h0000, 16'h0100, 16'h0140, 16'h5a5a, filler_mark,
        16'h0000, 16'h0100, 16'h0040, 16'h5a5a,
        16'h0000, 16'h01b8, 16'h3402, 16'h5f7f, filler_mark,
        16'h0000, 16'h0100, 16'h0000, 16'h5a5a
    };
    localparam int entry_len [n_entries] = '{13, 6, 4, 9};
    // Seq+GOP+ref 0, ref 5 out of order, ref 1, new GOP with ref 0
    localparam logic [15:0] exp_tc_hi [n_entries] = '{16'h0b4d, 16'h0b4d, 16'h0b4d, 16'h04be};
    localparam logic [15:0] exp_tc_lo [n_entries] = '{16'h0000, 16'h0000, 16'h0000, 16'h0000};
    localparam logic [15:0] exp_tmpref [n_entries] = '{16'h0000, 16'h0000, 16'h0004, 16'h0000};
    localparam logic [15:0] exp_isr [n_entries] = '{16'h0807, 16'h0804, 16'h0804, 16'h0806};

    logic        clk;
    logic        reset;
    logic [14:0] address;
    logic [15:0] din;
    logic [15:0] dout;
    logic        cs;
    logic        uds;
    logic        lds;
    logic        write_strobe;
    logic        bus_ack;
    logic        intreq;
    logic        vsync;

    int          mismatch_count = 0;
    int          failure_count = 0;
    logic [31:0] rng_state = 32'hab7e_4326;
    logic [15:0] rd;
    logic [15:0] word;
    logic [15:0] ier_value;
    int          w;
    int          wait_n;

    fmv_decoder dut_i (
        .clk(clk), .reset(reset), .address(address), .din(din), .dout(dout),
        .cs(cs), .uds(uds), .lds(lds), .write_strobe(write_strobe),
        .bus_ack(bus_ack), .intreq(intreq), .vsync(vsync)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    initial begin
        #(watchdog_cycles * 10);
        $display("Watchdog expired after %0d cycles without a verdict", watchdog_cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Filler never holds a zero byte, so the parser stays idle
    task automatic next_filler(output logic [15:0] value);
        do begin
            rng_state = xorshift32(rng_state);
            value = rng_state[15:0];
        end while (value[15:8] == 8'h00 || value[7:0] == 8'h00);
    endtask

    task automatic note_mismatch(input string msg);
        mismatch_count++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    // Returns at the falling edge before the acknowledged edge
    task automatic wait_ack();
        int n;
        n = 0;
        @(negedge clk);
        while (!bus_ack && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (!bus_ack) begin
            failure_count++;
            $display("Bus acknowledge never came at %0t", $time);
        end
    endtask

    task automatic bus_write(input logic [14:0] addr, input logic [15:0] data);
        @(negedge clk);
        address = addr;
        din = data;
        write_strobe = 1'b1;
        cs = 1'b1;
        wait_ack();
        @(negedge clk);
        cs = 1'b0;
        write_strobe = 1'b0;
    endtask

    task automatic bus_read(input logic [14:0] addr, output logic [15:0] data);
        @(negedge clk);
        address = addr;
        write_strobe = 1'b0;
        cs = 1'b1;
        wait_ack();
        data = dout;
        @(negedge clk);
        cs = 1'b0;
    endtask

    task automatic vsync_rise();
        @(negedge clk);
        vsync = 1'b1;
        repeat (2) @(negedge clk);
        vsync = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        reset = 1'b1;
        address = '0;
        din = '0;
        cs = 1'b0;
        uds = 1'b1;  // Word accesses only
        lds = 1'b1;
        write_strobe = 1'b0;
        vsync = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        if (intreq !== 1'b0 || bus_ack !== 1'b0)
            note_mismatch("intreq or bus_ack high after reset");
        bus_read(reg_isr, rd);
        if (rd !== 16'h0000)
            note_mismatch($sformatf("status after reset %h, expected 0000", rd));
        bus_read(reg_tcnt, rd);
        if (rd !== 16'd55)
            note_mismatch($sformatf("tcnt after reset %0d, expected 55", rd));

        bus_write(reg_ier, 16'ha5a5);
        bus_read(reg_ier, rd);
        if (rd !== 16'ha5a5)
            note_mismatch($sformatf("ier read %h, expected a5a5", rd));
        bus_write(reg_tcnt, 16'h0400);  // Keeps the timer quiet during the table
        bus_read(reg_tcnt, rd);
        if (rd !== 16'h0400)
            note_mismatch($sformatf("tcnt read %h, expected 0400", rd));

        ier_value = 16'h0001 << isr_pic;
        bus_write(reg_ier, ier_value);
        w = 0;
        for (int e = 0; e < n_entries; e++) begin
            for (int k = 0; k < entry_len[e]; k++) begin
                word = stim_words[w];
                if (word == filler_mark)
                    next_filler(word);
                bus_write(reg_xfer, word);
                w++;
            end
            repeat (2) vsync_rise();  // Second rise releases the event
            // Each entry ends in a picture and the pic bit is enabled
            if (intreq !== 1'b1)
                note_mismatch($sformatf("entry %0d intreq %b after release", e, intreq));
            bus_read(reg_timecd_hi, rd);
            if (rd !== exp_tc_hi[e])
                note_mismatch($sformatf("entry %0d timecode hi %h, exp %h", e, rd, exp_tc_hi[e]));
            bus_read(reg_timecd_lo, rd);
            if (rd !== exp_tc_lo[e])
                note_mismatch($sformatf("entry %0d timecode lo %h, exp %h", e, rd, exp_tc_lo[e]));
            bus_read(reg_tmpref, rd);
            if (rd !== exp_tmpref[e])
                note_mismatch($sformatf("entry %0d tmpref %h, exp %h", e, rd, exp_tmpref[e]));
            bus_read(reg_isr, rd);
            if (rd !== exp_isr[e])
                note_mismatch($sformatf("entry %0d status %h, exp %h", e, rd, exp_isr[e]));
            bus_read(reg_isr, rd);
            if (rd !== 16'h0000 || intreq !== 1'b0)
                note_mismatch($sformatf("entry %0d status %h not cleared by read", e, rd));
        end

        // Timer with compare 0 fires after 8 ticks
        ier_value = 16'h0001 << isr_tim;
        bus_write(reg_ier, ier_value);
        bus_write(reg_tcnt, 16'h0000);
        bus_write(reg_trld, 16'h0000);
        bus_read(reg_isr, rd);
        wait_n = 0;
        while (!intreq && wait_n < timer_cycles + 100) begin
            @(negedge clk);
            wait_n++;
        end
        if (!intreq) begin
            failure_count++;
            $display("Timer interrupt did not arrive within %0d cycles", timer_cycles + 100);
        end else if (wait_n < timer_cycles - 20) begin
            note_mismatch($sformatf("timer interrupt after only %0d cycles", wait_n));
        end
        bus_read(reg_isr, rd);
        if (rd !== ier_value)
            note_mismatch($sformatf("timer status %h, expected %h", rd, ier_value));
        if (intreq !== 1'b0)
            note_mismatch("intreq still high after the status read");

        $display("Checks done: %0d mismatches, %0d other failures",
                 mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
verilog/fmv_regs_pkg.sv
verilog/fmv_stream_pkg.sv
verilog/fmv_host_regs.sv
verilog/fmv_header_parser.sv
verilog/fmv_system_timer.sv
verilog/fmv_event_fifo.sv
verilog/fmv_decoder.sv
dv/fmv_decoder_props.sv
dv/fmv_decoder_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the decoder testbench with Verilator
set -u
cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -f sources.f --top-module fmv_decoder_tb \
    -Mdir "$build_dir" -o fmv_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/fmv_sim" | tee "$log_file"
if [ "${PIPESTATUS[0]}" -ne 0 ]; then
    echo "Simulation exited with an error status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$log_file"; then
    echo "Testbench reported failure, see $log_file"
    exit 1
fi

echo "Run complete, log in $log_file"
exit 0
